// ==== icache.f ====
icache_pkg.sv
icache_tag_store.sv
icache_data_store.sv
icache_repl.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// ==== icache_ctrl.sv ====
// icache controller
// fetch and refill sequencing, flush handling and memory request generation
module icache_ctrl import icache_pkg::*; #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 16,
  localparam int unsigned IdxW   = $clog2(NumSets),
  localparam int unsigned TagW   = ADDR_W - IdxW - OFFSET_W
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                en_i,
  input  logic                fetch_req_i,
  input  addr_t               fetch_addr_i,
  input  logic [NumWays-1:0]  hit_i,
  input  logic                flush_done_i,
  input  logic                mem_ack_i,
  input  logic                mem_rtrn_vld_i,
  output logic                fetch_ready_o,
  output logic                fetch_valid_o,
  output logic                lookup_en_o,
  output logic                fill_en_o,
  output logic                flush_en_o,
  output logic                cmp_valid_o,
  output logic [IdxW-1:0]     index_o,
  output logic [OFFSET_W-1:0] offset_o,
  output logic [TagW-1:0]     tag_o,
  output logic                mem_req_o,
  output addr_t               mem_addr_o,
  output logic                mem_nc_o,
  output logic                busy_o,
  output logic                miss_o
);

  icache_state_e state_d, state_q;
  logic          en_d, en_q;
  logic          flush_d, flush_q;
  logic          nc_q;
  logic          accept;
  logic          hit;
  addr_t         addr_q;

  ////////////////////////////////////////////////////
  // address split and memory address
  ////////////////////////////////////////////////////

  assign accept = fetch_ready_o & fetch_req_i;

  // lookup uses the incoming address, fill uses the held one
  assign index_o  = accept ? fetch_addr_i[OFFSET_W +: IdxW] : addr_q[OFFSET_W +: IdxW];
  assign offset_o = addr_q[OFFSET_W-1:0];
  assign tag_o    = addr_q[ADDR_W-1 -: TagW];

  // word address for non-cacheable reads, line address otherwise
  assign mem_addr_o = nc_q ? {addr_q[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}} :
                             {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign mem_nc_o   = nc_q;

  // tag compare only means something for cacheable reads
  assign cmp_valid_o = (state_q == READ) & ~nc_q;
  assign hit         = cmp_valid_o & (|hit_i);
  assign lookup_en_o = accept & en_q;
  assign busy_o      = (state_q != IDLE);

  ////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    // disabling takes effect at once, enabling only through a flush
    en_d          = en_q & en_i;
    // collect flush requests, including one for re-enabling
    flush_d       = flush_q | flush_i | (en_i & ~en_q);
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    flush_en_o    = 1'b0;
    fill_en_o     = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done_i) begin
          state_d = IDLE;
          flush_d = 1'b0;
          en_d    = en_i;
        end
      end
      // pending flush goes first, then new fetches
      IDLE: begin
        if (flush_d) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            state_d = READ;
          end
        end
      end
      // hit returns now, anything else asks memory
      READ: begin
        if (hit) begin
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            // only cacheable misses count
            miss_o  = ~nc_q;
            state_d = MISS;
          end
        end
      end
      // return is taken unconditionally
      MISS: begin
        if (mem_rtrn_vld_i) begin
          fetch_valid_o = 1'b1;
          fill_en_o     = ~nc_q;
          state_d       = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FLUSH;
      en_q    <= 1'b0;
      flush_q <= 1'b0;
      nc_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      en_q    <= en_d;
      flush_q <= flush_d;
      // a fetch accepted while disabled bypasses the arrays
      if (accept) begin
        nc_q <= ~en_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
  end

endmodule

// ==== icache_data_store.sv ====
// icache data store
// line arrays per way, word select from the hit way or from the refill line
module icache_data_store import icache_pkg::*; #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 16,
  localparam int unsigned IdxW   = $clog2(NumSets)
) (
  input  logic                clk_i,
  input  logic                lookup_en_i,
  input  logic                fill_en_i,
  input  logic [IdxW-1:0]     index_i,
  input  logic [OFFSET_W-1:0] offset_i,
  input  logic [NumWays-1:0]  repl_way_oh_i,
  input  logic [NumWays-1:0]  hit_i,
  input  logic                cmp_valid_i,
  input  line_t               rtrn_data_i,
  output fetch_data_t         fetch_data_o
);

  localparam int unsigned WordSelW = OFFSET_W - BYTE_OFF_W;

  logic [WordSelW-1:0]              word_sel;
  logic [NumWays-1:0][FETCH_W-1:0]  way_word;
  fetch_data_t                      hit_word;
  fetch_data_t                      rtrn_word;

  // word number inside the line
  assign word_sel = offset_i[OFFSET_W-1:BYTE_OFF_W];

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    line_t mem_q [NumSets];
    line_t rdata_q;

    always_ff @(posedge clk_i) begin
      if (fill_en_i && repl_way_oh_i[w]) begin
        mem_q[index_i] <= rtrn_data_i;
      end
      if (lookup_en_i) begin
        rdata_q <= mem_q[index_i];
      end
    end

    assign way_word[w] = rdata_q[word_sel*FETCH_W +: FETCH_W];
  end

  // hit vector is one-hot, so an or over the masked words selects it
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (hit_i[w]) begin
        hit_word = hit_word | way_word[w];
      end
    end
  end

  // miss and non-cacheable data come straight from the return line
  assign rtrn_word    = rtrn_data_i[word_sel*FETCH_W +: FETCH_W];
  assign fetch_data_o = cmp_valid_i ? hit_word : rtrn_word;

endmodule

// ==== icache_pkg.sv ====
// instruction cache shared definitions
// widths, address and data types, and controller states
package icache_pkg;

  ////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////

  // physical byte address
  localparam int unsigned ADDR_W     = 32;
  // one instruction word
  localparam int unsigned FETCH_W    = 32;
  // one cache line, four instruction words
  localparam int unsigned LINE_W     = 128;
  // byte offset inside a line
  localparam int unsigned OFFSET_W   = 4;
  // byte offset inside one instruction word
  localparam int unsigned BYTE_OFF_W = 2;

  ////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [FETCH_W-1:0] fetch_data_t;
  // line as held in the data arrays and as returned by memory
  typedef logic [LINE_W-1:0]  line_t;

  // controller states
  // FLUSH clears all valid bits and is also the reset state
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } icache_state_e;

endpackage

// ==== icache_repl.sv ====
// icache replacement unit
// lowest invalid way first, otherwise a way from an 8-bit LFSR
module icache_repl #(
  parameter int unsigned NumWays = 4,
  localparam int unsigned WayW   = $clog2(NumWays)
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NumWays-1:0] valid_i,
  input  logic               cmp_valid_i,
  input  logic               fill_en_i,
  output logic [NumWays-1:0] repl_way_oh_o
);

  logic [7:0]      lfsr_q;
  logic            lfsr_fb;
  logic            all_valid;
  logic [WayW-1:0] inv_way;
  logic [WayW-1:0] rnd_way;
  logic [WayW-1:0] repl_way;

  assign all_valid = &valid_i;

  // search downwards so the lowest invalid way wins
  always_comb begin
    inv_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = WayW'(w);
      end
    end
  end

  // fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  assign rnd_way = lfsr_q[WayW-1:0];

  assign repl_way = all_valid ? rnd_way : inv_way;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q        <= 8'hA5;
      repl_way_oh_o <= '0;
    end else begin
      // only random fills move the sequence on
      if (fill_en_i && all_valid) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
      // capture during the compare, then hold through the miss
      if (cmp_valid_i) begin
        repl_way_oh_o <= NumWays'(1) << repl_way;
      end
    end
  end

endmodule

// ==== icache_tag_store.sv ====
// icache tag store
// tag and valid arrays per way, flush walker, tag compare and hit vector
module icache_tag_store import icache_pkg::*; #(
  parameter int unsigned NumWays  = 4,
  parameter int unsigned NumSets  = 16,
  localparam int unsigned IdxW    = $clog2(NumSets),
  localparam int unsigned TagW    = ADDR_W - IdxW - OFFSET_W
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               lookup_en_i,
  input  logic               fill_en_i,
  input  logic               flush_en_i,
  input  logic [IdxW-1:0]    index_i,
  input  logic [TagW-1:0]    tag_i,
  input  logic [NumWays-1:0] repl_way_oh_i,
  output logic [NumWays-1:0] hit_o,
  output logic [NumWays-1:0] valid_o,
  output logic               flush_done_o
);

  logic [IdxW-1:0] flush_cnt_q;
  logic [IdxW-1:0] addr;
  logic [TagW:0]   wdata;

  ////////////////////////////////////////////////////
  // flush walker
  ////////////////////////////////////////////////////

  // last set reached while flushing
  assign flush_done_o = flush_en_i && (flush_cnt_q == IdxW'(NumSets - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_cnt_q <= '0;
    end else if (flush_done_o) begin
      flush_cnt_q <= '0;
    end else if (flush_en_i) begin
      flush_cnt_q <= flush_cnt_q + 1'b1;
    end
  end

  // the walker owns the array address during a flush
  assign addr  = flush_en_i ? flush_cnt_q : index_i;
  // valid bit on top, tag below
  // flush writes all zero, fill writes the saved tag as valid
  assign wdata = flush_en_i ? '0 : {1'b1, tag_i};

  ////////////////////////////////////////////////////
  // arrays and compare
  ////////////////////////////////////////////////////

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    logic [TagW:0] mem_q [NumSets];
    logic [TagW:0] rdata_q;
    logic          we;

    // flush clears every way, fill only the chosen one
    assign we = flush_en_i | (fill_en_i & repl_way_oh_i[w]);

    always_ff @(posedge clk_i) begin
      if (we) begin
        mem_q[addr] <= wdata;
      end
      // registered read, held until the next lookup
      if (lookup_en_i) begin
        rdata_q <= mem_q[addr];
      end
    end

    assign valid_o[w] = rdata_q[TagW];
    // a hit needs a matching tag in a valid entry
    assign hit_o[w]   = valid_o[w] && (rdata_q[TagW-1:0] == tag_i);
  end

endmodule

// ==== icache_top.sv ====
// set-associative read-only instruction cache
// controller, tag store, data store and replacement unit
module icache_top import icache_pkg::*; #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 16,
  localparam int unsigned IdxW   = $clog2(NumSets),
  localparam int unsigned TagW   = ADDR_W - IdxW - OFFSET_W
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  input  logic        en_i,
  input  logic        fetch_req_i,
  input  addr_t       fetch_addr_i,
  output logic        fetch_ready_o,
  output logic        fetch_valid_o,
  output fetch_data_t fetch_data_o,
  output logic        mem_req_o,
  input  logic        mem_ack_i,
  output addr_t       mem_addr_o,
  output logic        mem_nc_o,
  input  logic        mem_rtrn_vld_i,
  input  line_t       mem_rtrn_data_i,
  output logic        busy_o,
  output logic        miss_o
);

  logic                lookup_en;
  logic                fill_en;
  logic                flush_en;
  logic                cmp_valid;
  logic [IdxW-1:0]     index;
  logic [OFFSET_W-1:0] offset;
  logic [TagW-1:0]     tag;
  logic [NumWays-1:0]  hit;
  logic [NumWays-1:0]  valid;
  logic                flush_done;
  logic [NumWays-1:0]  repl_way_oh;

  // sequencing and both external handshakes
  icache_ctrl #(
    .NumWays (NumWays),
    .NumSets (NumSets)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .en_i           (en_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .hit_i          (hit),
    .flush_done_i   (flush_done),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_valid_o  (fetch_valid_o),
    .lookup_en_o    (lookup_en),
    .fill_en_o      (fill_en),
    .flush_en_o     (flush_en),
    .cmp_valid_o    (cmp_valid),
    .index_o        (index),
    .offset_o       (offset),
    .tag_o          (tag),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_nc_o       (mem_nc_o),
    .busy_o         (busy_o),
    .miss_o         (miss_o)
  );

  icache_tag_store #(
    .NumWays (NumWays),
    .NumSets (NumSets)
  ) u_tag_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_en_i   (lookup_en),
    .fill_en_i     (fill_en),
    .flush_en_i    (flush_en),
    .index_i       (index),
    .tag_i         (tag),
    .repl_way_oh_i (repl_way_oh),
    .hit_o         (hit),
    .valid_o       (valid),
    .flush_done_o  (flush_done)
  );

  // fetch word comes out of here
  icache_data_store #(
    .NumWays (NumWays),
    .NumSets (NumSets)
  ) u_data_store (
    .clk_i         (clk_i),
    .lookup_en_i   (lookup_en),
    .fill_en_i     (fill_en),
    .index_i       (index),
    .offset_i      (offset),
    .repl_way_oh_i (repl_way_oh),
    .hit_i         (hit),
    .cmp_valid_i   (cmp_valid),
    .rtrn_data_i   (mem_rtrn_data_i),
    .fetch_data_o  (fetch_data_o)
  );

  icache_repl #(
    .NumWays (NumWays)
  ) u_repl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (valid),
    .cmp_valid_i   (cmp_valid),
    .fill_en_i     (fill_en),
    .repl_way_oh_o (repl_way_oh)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_icache -f icache.f
out=$(./obj_dir/Vtb_icache)
echo "$out"
if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// ==== tb_icache.sv ====
// instruction cache testbench
// table-driven fetch, flush and enable sequences against a line memory model
module tb_icache import icache_pkg::*; ();

  localparam int unsigned Timeout  = 200;
  localparam int unsigned NumSteps = 32;

  typedef enum logic [2:0] {
    OP_FETCH,
    OP_FLUSH,
    OP_EN,
    OP_DIS,
    OP_MARK,
    OP_MIN
  } op_e;

  // exp 0 hit, 1 miss, 2 either; for OP_MIN the least number of misses
  typedef struct packed {
    op_e        op;
    addr_t      addr;
    logic [1:0] exp;
  } step_t;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  logic        en_i;
  logic        fetch_req_i;
  addr_t       fetch_addr_i;
  logic        fetch_ready_o;
  logic        fetch_valid_o;
  fetch_data_t fetch_data_o;
  logic        mem_req_o;
  logic        mem_ack_i;
  addr_t       mem_addr_o;
  logic        mem_nc_o;
  logic        mem_rtrn_vld_i;
  line_t       mem_rtrn_data_i;
  logic        busy_o;
  logic        miss_o;

  step_t       steps [NumSteps];
  int unsigned errors    = 0;
  int unsigned timeouts  = 0;
  int unsigned valid_cnt = 0;
  int unsigned miss_cnt  = 0;
  int unsigned mark_cnt  = 0;
  int unsigned fetch_cnt = 0;
  fetch_data_t last_data;

  icache_top #(
    .NumWays (4),
    .NumSets (16)
  ) u_icache_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .en_i            (en_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_data_o    (fetch_data_o),
    .mem_req_o       (mem_req_o),
    .mem_ack_i       (mem_ack_i),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .busy_o          (busy_o),
    .miss_o          (miss_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // count response pulses just before the edge that ends them
  always @(posedge clk_i) begin
    if (fetch_valid_o) begin
      valid_cnt <= valid_cnt + 1;
      last_data <= fetch_data_o;
    end
    if (miss_o) begin
      miss_cnt <= miss_cnt + 1;
    end
  end

  //////////////////////////////////////////////////
  // waits and memory model
  //////////////////////////////////////////////////

  task automatic wait_ready();
    int unsigned n;
    n = 0;
    while (!fetch_ready_o && n < Timeout) begin
      @(negedge clk_i);
      n++;
    end
    if (!fetch_ready_o) begin
      $display("fetch_ready_o never came up");
      timeouts++;
    end
  endtask

  task automatic wait_idle();
    int unsigned n;
    n = 0;
    while (busy_o && n < Timeout) begin
      @(negedge clk_i);
      n++;
    end
    if (busy_o) begin
      $display("busy_o stayed high, the flush did not finish");
      timeouts++;
    end
  endtask

  // single control bit against its expected level
  task automatic check_level(input string name, input logic got, input logic exp_val);
    if (got !== exp_val) begin
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp_val);
      errors++;
    end
  endtask

  // ack after 0 to 3 cycles, line back 2 to 5 cycles after the ack
  task automatic serve_mem(input addr_t addr, input logic nc_exp);
    addr_t       exp_addr;
    addr_t       base;
    int unsigned dly;
    line_t       line;
    exp_addr = nc_exp ? {addr[31:2], 2'b00} : {addr[31:4], 4'h0};
    base     = {addr[31:4], 4'h0};
    if (mem_addr_o !== exp_addr) begin
      $display("Error: mem_addr_o = 0x%08h, expected 0x%08h", mem_addr_o, exp_addr);
      errors++;
    end
    if (mem_nc_o !== nc_exp) begin
      $display("Error: mem_nc_o = 0x%0h, expected 0x%0h", mem_nc_o, nc_exp);
      errors++;
    end
    dly = $urandom % 4;
    repeat (dly) begin
      @(negedge clk_i);
      if (!mem_req_o) begin
        $display("mem_req_o dropped before it was acknowledged");
        errors++;
      end
    end
    mem_ack_i = 1'b1;
    @(negedge clk_i);
    mem_ack_i = 1'b0;
    dly = 2 + $urandom % 4;
    repeat (dly - 1) @(negedge clk_i);
    // every word holds its own byte address xor the marker
    for (int w = 0; w < 4; w++) begin
      line[w*32 +: 32] = (base + 32'(4 * w)) ^ 32'hA5A5_0000;
    end
    mem_rtrn_data_i = line;
    mem_rtrn_vld_i  = 1'b1;
    @(negedge clk_i);
    mem_rtrn_vld_i  = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // one fetch with its checks
  //////////////////////////////////////////////////

  task automatic run_fetch(input addr_t addr, input logic [1:0] exp);
    int unsigned v0;
    int unsigned m0;
    int unsigned n;
    logic        nc_exp;
    logic        req_exp;
    logic        req_seen;
    fetch_data_t exp_data;
    v0       = valid_cnt;
    m0       = miss_cnt;
    nc_exp   = ~en_i;
    req_exp  = nc_exp || (exp == 2'd1);
    req_seen = 1'b0;
    exp_data = addr ^ 32'hA5A5_0000;
    wait_ready();
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr;
    fetch_cnt++;
    @(negedge clk_i);
    // a hit answers in the cycle after the accept
    if (exp == 2'd0 && !nc_exp && !fetch_valid_o) begin
      $display("Error: fetch_valid_o = 0x0, expected 0x1 after accept of 0x%08h", addr);
      errors++;
    end
    fetch_req_i = 1'b0;
    n = 0;
    while (valid_cnt == v0 && n < Timeout) begin
      if (mem_req_o) begin
        req_seen = 1'b1;
        serve_mem(addr, nc_exp);
      end else begin
        @(negedge clk_i);
      end
      n++;
    end
    if (valid_cnt == v0) begin
      $display("no fetch_valid_o for address 0x%08h", addr);
      timeouts++;
    end else begin
      if (valid_cnt - v0 != 1) begin
        $display("Error: fetch_valid_o pulses = 0x%0h, expected 0x1", valid_cnt - v0);
        errors++;
      end
      if (last_data !== exp_data) begin
        $display("Error: fetch_data_o = 0x%08h, expected 0x%08h", last_data, exp_data);
        errors++;
      end
    end
    if (exp != 2'd2 && req_seen != req_exp) begin
      $display("Error: mem_req_o = 0x%0h, expected 0x%0h for 0x%08h", req_seen, req_exp, addr);
      errors++;
    end
    if (exp != 2'd2 && (miss_cnt - m0) != 32'(exp == 2'd1)) begin
      $display("Error: miss_o pulses = 0x%0h, expected 0x%0h", miss_cnt - m0, exp == 2'd1);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus table and main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_ni          = 1'b0;
    flush_i         = 1'b0;
    en_i            = 1'b1;
    fetch_req_i     = 1'b0;
    fetch_addr_i    = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    void'($urandom(22363));
    steps = '{
      '{OP_FETCH, 32'h0000_1000, 2'd1},  // cold line
      '{OP_FETCH, 32'h0000_1004, 2'd0},
      '{OP_FETCH, 32'h0000_100C, 2'd0},
      '{OP_FETCH, 32'h1000_0030, 2'd1},  // four tags into set 3
      '{OP_FETCH, 32'h2000_0034, 2'd1},
      '{OP_FETCH, 32'h3000_0038, 2'd1},
      '{OP_FETCH, 32'h4000_003C, 2'd1},
      '{OP_FETCH, 32'h1000_003C, 2'd0},
      '{OP_FETCH, 32'h2000_0030, 2'd0},
      '{OP_FETCH, 32'h3000_0034, 2'd0},
      '{OP_FETCH, 32'h4000_0038, 2'd0},
      '{OP_FLUSH, 32'h0000_0000, 2'd0},
      '{OP_FETCH, 32'h0000_1008, 2'd1},
      '{OP_FETCH, 32'h2000_0030, 2'd1},
      '{OP_DIS,   32'h0000_0000, 2'd0},  // bypass, even for a cached line
      '{OP_FETCH, 32'h0000_2004, 2'd0},
      '{OP_FETCH, 32'h0000_1008, 2'd0},
      '{OP_EN,    32'h0000_0000, 2'd0},
      '{OP_FETCH, 32'h0000_2004, 2'd1},
      '{OP_FETCH, 32'h0000_2008, 2'd0},
      '{OP_FETCH, 32'h1000_0050, 2'd1},  // fill set 5, then a fifth tag
      '{OP_FETCH, 32'h2000_0054, 2'd1},
      '{OP_FETCH, 32'h3000_0058, 2'd1},
      '{OP_FETCH, 32'h4000_005C, 2'd1},
      '{OP_FETCH, 32'h5000_0050, 2'd1},
      '{OP_MARK,  32'h0000_0000, 2'd0},
      '{OP_FETCH, 32'h1000_0054, 2'd2},
      '{OP_FETCH, 32'h2000_0058, 2'd2},
      '{OP_FETCH, 32'h3000_005C, 2'd2},
      '{OP_FETCH, 32'h4000_0050, 2'd2},
      // the evicted tag misses, its refill may push out one more
      '{OP_MIN,   32'h0000_0000, 2'd1},
      '{OP_FETCH, 32'h5000_0058, 2'd2}
    };
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    // reset leaves the controller flushing with every pulse output low
    check_level("fetch_ready_o", fetch_ready_o, 1'b0);
    check_level("fetch_valid_o", fetch_valid_o, 1'b0);
    check_level("mem_req_o", mem_req_o, 1'b0);
    check_level("miss_o", miss_o, 1'b0);
    check_level("busy_o", busy_o, 1'b1);
    wait_idle();
    for (int i = 0; i < NumSteps; i++) begin
      case (steps[i].op)
        OP_FETCH: run_fetch(steps[i].addr, steps[i].exp);
        OP_FLUSH: begin
          flush_i = 1'b1;
          @(negedge clk_i);
          flush_i = 1'b0;
          check_level("busy_o", busy_o, 1'b1);
          wait_idle();
        end
        OP_EN: begin
          en_i = 1'b1;
          @(negedge clk_i);
          // re-enabling starts a flush
          check_level("busy_o", busy_o, 1'b1);
          wait_idle();
        end
        OP_DIS: begin
          en_i = 1'b0;
          @(negedge clk_i);
        end
        OP_MARK: mark_cnt = miss_cnt;
        default: begin
          if (miss_cnt - mark_cnt < 32'(steps[i].exp)) begin
            $display("Error: miss_o pulses = 0x%0h, expected at least 0x%0h",
                     miss_cnt - mark_cnt, steps[i].exp);
            errors++;
          end
        end
      endcase
    end
    repeat (2) @(negedge clk_i);
    // one response per accepted fetch over the whole run
    if (valid_cnt != fetch_cnt) begin
      $display("Error: fetch_valid_o pulses = 0x%0h, expected 0x%0h", valid_cnt, fetch_cnt);
      errors++;
    end
    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
